/* design/lab4_ctrl_pkg.sv */
package lab4_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths

	// one LAB4 serial word, shifted MSB first
	localparam int LAB_WORD_WIDTH = 24;

	// chip select field in the user write register
	localparam int LAB_SEL_WIDTH = 5;

	// all ones in the select means every chip, so one code is reserved
	localparam int MAX_LABS = (1 << LAB_SEL_WIDTH) - 1;

	// shift clock prescale
	localparam int PRESCALE_WIDTH = 8;
	localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_RESET = 8'd1;

	////////////////////////////////////////////////////////////////////////////
	// register map, byte offsets on the host bus

	localparam logic [6:0] REG_CONTROL    = 7'h00;
	localparam logic [6:0] REG_PRESCALE   = 7'h04;
	localparam logic [6:0] REG_USER_WRITE = 7'h18;
	localparam logic [6:0] REG_STATUS     = 7'h20;

	// regclear field position in the control word
	localparam int REGCLR_LSB = 16;

	////////////////////////////////////////////////////////////////////////////
	// bundles

	// one host bus request, as seen by the slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [6:0]  adr;
		logic [31:0] dat;
	} bus_req_t;

	// serial write command; sel sits above the word, as in the register
	typedef struct packed {
		logic [LAB_SEL_WIDTH-1:0]  sel;
		logic [LAB_WORD_WIDTH-1:0] word;
	} lab_cmd_t;

	// what the host reads back from the status register
	typedef struct packed {
		logic                      busy;
		logic [LAB_WORD_WIDTH-1:0] readback;
	} serial_status_t;

endpackage

/* design/lab4_reg_bank.sv */
`timescale 1ns/1ps

module lab4_reg_bank #(
	parameter int NUM_REGCLR = 1
) (
	input  logic                                       clk_i,
	input  logic                                       rst_i,
	input  lab4_ctrl_pkg::bus_req_t                    bus_i,
	output logic                                       ack_o,
	output logic [31:0]                                rd_data_o,
	output logic                                       start_o,
	output lab4_ctrl_pkg::lab_cmd_t                    cmd_o,
	output logic [lab4_ctrl_pkg::PRESCALE_WIDTH-1:0]   prescale_o,
	output logic [NUM_REGCLR-1:0]                      regclr_o,
	input  logic                                       done_i,
	input  logic [lab4_ctrl_pkg::LAB_WORD_WIDTH-1:0]   readback_i,
	input  logic                                       busy_i
);

	localparam int W  = lab4_ctrl_pkg::LAB_WORD_WIDTH;
	localparam int SW = lab4_ctrl_pkg::LAB_SEL_WIDTH;

	logic                          bus_hit;
	logic                          wr_stb;
	logic                          user_wr;
	logic                          request_q;
	logic [31:0]                   control_word;
	lab4_ctrl_pkg::serial_status_t status;

	assign bus_hit = bus_i.cyc && bus_i.stb;

	// writes land only in the first cycle of a bus cycle, before ack comes back
	assign wr_stb = bus_hit && bus_i.we && !ack_o;

	// user writes bounce off while a serial write is still pending
	assign user_wr = wr_stb && (bus_i.adr == lab4_ctrl_pkg::REG_USER_WRITE) && !request_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= bus_hit;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control and prescale

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			regclr_o   <= '0;
			prescale_o <= lab4_ctrl_pkg::PRESCALE_RESET;
		end else if (wr_stb) begin
			if (bus_i.adr == lab4_ctrl_pkg::REG_CONTROL) begin
				regclr_o <= bus_i.dat[lab4_ctrl_pkg::REGCLR_LSB +: NUM_REGCLR];
			end
			if (bus_i.adr == lab4_ctrl_pkg::REG_PRESCALE) begin
				prescale_o <= bus_i.dat[lab4_ctrl_pkg::PRESCALE_WIDTH-1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// user serial write

	// bit 31 kicks off the engine, done from the collector drops it again
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			request_q <= 1'b0;
			start_o   <= 1'b0;
		end else begin
			start_o <= user_wr && bus_i.dat[31];
			if (user_wr) begin
				request_q <= bus_i.dat[31];
			end else if (done_i) begin
				request_q <= 1'b0;
			end
		end
	end

	// command stays put for the whole serial write
	always_ff @(posedge clk_i) begin
		if (user_wr) begin
			cmd_o.sel  <= bus_i.dat[W +: SW];
			cmd_o.word <= bus_i.dat[W-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read side

	always_comb begin
		control_word = '0;
		control_word[lab4_ctrl_pkg::REGCLR_LSB +: NUM_REGCLR] = regclr_o;
	end

	assign status.busy     = busy_i;
	assign status.readback = readback_i;

	always_comb begin
		case (bus_i.adr)
			lab4_ctrl_pkg::REG_CONTROL: begin
				rd_data_o = control_word;
			end
			lab4_ctrl_pkg::REG_PRESCALE: begin
				rd_data_o = {{(32-lab4_ctrl_pkg::PRESCALE_WIDTH){1'b0}}, prescale_o};
			end
			lab4_ctrl_pkg::REG_USER_WRITE: begin
				rd_data_o = {request_q, {(31-$bits(cmd_o)){1'b0}}, cmd_o};
			end
			lab4_ctrl_pkg::REG_STATUS: begin
				// busy on top, last readback word in the low bits
				rd_data_o = {status.busy, {(32-$bits(status)){1'b0}}, status.readback};
			end
			default: begin
				rd_data_o = '0;
			end
		endcase
	end

endmodule

/* design/lab4_serial_dispatch.sv */
`timescale 1ns/1ps

module lab4_serial_dispatch #(
	parameter int NUM_LABS = 8
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    start_i,
	input  lab4_ctrl_pkg::lab_cmd_t cmd_i,
	input  logic [NUM_LABS-1:0]     chan_disable_i,
	output logic [NUM_LABS-1:0]     req_o,
	input  logic [NUM_LABS-1:0]     ack_i,
	output logic [NUM_LABS-1:0]     mask_o,
	output logic                    busy_o
);

	logic                sel_all;
	logic [NUM_LABS-1:0] target;

	// the select field cannot reach past MAX_LABS chips
	if (NUM_LABS < 1 || NUM_LABS > lab4_ctrl_pkg::MAX_LABS) begin : g_count_check
		$error("NUM_LABS out of range for the select field");
	end

	assign sel_all = &cmd_i.sel;

	////////////////////////////////////////////////////////////////////////////
	// target mask

	// selects at or past NUM_LABS never match, so they give an empty mask
	always_comb begin
		for (int i = 0; i < NUM_LABS; i++) begin
			target[i] = sel_all || (int'(cmd_i.sel) == i);
		end
	end

	// only meaningful in the start cycle
	assign mask_o = start_i ? (target & ~chan_disable_i) : '0;

	////////////////////////////////////////////////////////////////////////////
	// four-phase requests

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_o  <= '0;
			busy_o <= 1'b0;
		end else begin
			// req falls on the ack, the shifter then drops ack on its own
			req_o <= (req_o & ~ack_i) | mask_o;

			if (start_i) begin
				busy_o <= 1'b1;
			end else if (!(|req_o) && !(|ack_i)) begin
				busy_o <= 1'b0;
			end
		end
	end

endmodule

/* design/lab4_serial_shifter.sv */
`timescale 1ns/1ps

module lab4_serial_shifter (
	input  logic                                     clk_i,
	input  logic                                     rst_i,
	input  logic                                     req_i,
	output logic                                     ack_o,
	input  logic [lab4_ctrl_pkg::LAB_WORD_WIDTH-1:0] word_i,
	input  logic [lab4_ctrl_pkg::PRESCALE_WIDTH-1:0] prescale_i,
	input  logic                                     shout_i,
	output logic                                     sin_o,
	output logic                                     sclk_o,
	output logic                                     pclk_o,
	output logic [lab4_ctrl_pkg::LAB_WORD_WIDTH-1:0] readback_o
);

	localparam int W  = lab4_ctrl_pkg::LAB_WORD_WIDTH;
	localparam int PW = lab4_ctrl_pkg::PRESCALE_WIDTH;

	// two phases per bit, then one low tail phase and one pclk phase
	localparam int SHIFT_PHASES = 2 * W;
	localparam int LAST_PHASE   = SHIFT_PHASES + 1;
	localparam int IDX_W        = $clog2(LAST_PHASE + 2);

	logic             active_q;
	logic             start;
	logic             phase_end;
	logic [PW-1:0]    phase_cnt_q;
	logic [IDX_W-1:0] phase_idx_q;
	logic [IDX_W-1:0] next_idx;
	logic             next_in_shift;
	logic [W-1:0]     shift_q;

	assign start         = !active_q && req_i && !ack_o;
	assign phase_end     = (phase_cnt_q == '0);
	assign next_idx      = phase_idx_q + 1'b1;
	assign next_in_shift = (next_idx < IDX_W'(SHIFT_PHASES));

	////////////////////////////////////////////////////////////////////////////
	// phase sequencer

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_q    <= 1'b0;
			ack_o       <= 1'b0;
			sin_o       <= 1'b0;
			sclk_o      <= 1'b0;
			pclk_o      <= 1'b0;
			phase_cnt_q <= '0;
			phase_idx_q <= '0;
		end else if (!active_q) begin
			if (start) begin
				active_q    <= 1'b1;
				phase_cnt_q <= prescale_i;
				phase_idx_q <= '0;
				sin_o       <= word_i[W-1];
			end else if (!req_i) begin
				ack_o <= 1'b0;
			end
		end else if (!phase_end) begin
			phase_cnt_q <= phase_cnt_q - 1'b1;
		end else begin
			phase_cnt_q <= prescale_i;
			phase_idx_q <= next_idx;
			if (phase_idx_q == IDX_W'(LAST_PHASE)) begin
				pclk_o   <= 1'b0;
				active_q <= 1'b0;
				ack_o    <= 1'b1;
			end else if (next_idx == IDX_W'(LAST_PHASE)) begin
				// word is complete in the chip, latch it
				pclk_o <= 1'b1;
			end else if (next_in_shift) begin
				// odd phases have sclk high, even phases set up the next bit
				sclk_o <= next_idx[0];
				if (!next_idx[0]) begin
					sin_o <= shift_q[W-2];
				end
			end else begin
				sclk_o <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// data path

	// shout still shows the current bit here, the chip only moves on the
	// sclk edge this same clock produces
	always_ff @(posedge clk_i) begin
		if (start) begin
			shift_q <= word_i;
		end else if (active_q && phase_end && next_in_shift) begin
			if (next_idx[0]) begin
				readback_o <= {readback_o[W-2:0], shout_i};
			end else begin
				shift_q <= {shift_q[W-2:0], 1'b0};
			end
		end
	end

endmodule

/* design/lab4_shout_collect.sv */
`timescale 1ns/1ps

module lab4_shout_collect #(
	parameter int NUM_LABS = 8
) (
	input  logic                                              clk_i,
	input  logic                                              rst_i,
	input  logic                                              start_i,
	input  logic [NUM_LABS-1:0]                               mask_i,
	input  logic [NUM_LABS-1:0]                               ack_i,
	input  logic [NUM_LABS*lab4_ctrl_pkg::LAB_WORD_WIDTH-1:0] readback_i,
	output logic                                              done_o,
	output logic [lab4_ctrl_pkg::LAB_WORD_WIDTH-1:0]          readback_o
);

	localparam int W = lab4_ctrl_pkg::LAB_WORD_WIDTH;

	logic                active_q;
	logic [NUM_LABS-1:0] ack_q;
	logic [NUM_LABS-1:0] pending_q;
	logic [NUM_LABS-1:0] first_q;
	logic [W-1:0]        first_word;

	// one-hot lowest chip picks the readback word
	always_comb begin
		first_word = '0;
		for (int i = 0; i < NUM_LABS; i++) begin
			if (first_q[i]) begin
				first_word = readback_i[i*W +: W];
			end
		end
	end

	// empty mask ends right away
	assign done_o = active_q && !(|pending_q);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_q  <= 1'b0;
			ack_q     <= '0;
			pending_q <= '0;
		end else begin
			ack_q <= ack_i;
			if (start_i) begin
				active_q  <= 1'b1;
				pending_q <= mask_i;
			end else begin
				pending_q <= pending_q & ~(ack_i & ~ack_q);
				if (done_o) begin
					active_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i) begin
			first_q <= mask_i & (~mask_i + NUM_LABS'(1));
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			readback_o <= '0;
		end else if (done_o && |first_q) begin
			readback_o <= first_word;
		end
	end

endmodule

/* design/lab4_serial_ctrl_top.sv */
`timescale 1ns/1ps

module lab4_serial_ctrl_top #(
	parameter int NUM_LABS   = 8,
	parameter int NUM_REGCLR = 1
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  lab4_ctrl_pkg::bus_req_t bus_i,
	output logic                    ack_o,
	output logic [31:0]             rd_data_o,
	input  logic [NUM_LABS-1:0]     chan_disable_i,
	input  logic [NUM_LABS-1:0]     shout_i,
	output logic [NUM_LABS-1:0]     sin_o,
	output logic [NUM_LABS-1:0]     sclk_o,
	output logic [NUM_LABS-1:0]     pclk_o,
	output logic [NUM_REGCLR-1:0]   regclr_o
);

	localparam int W = lab4_ctrl_pkg::LAB_WORD_WIDTH;

	logic                                     start;
	lab4_ctrl_pkg::lab_cmd_t                  cmd;
	logic [lab4_ctrl_pkg::PRESCALE_WIDTH-1:0] prescale;
	logic                                     done;
	logic [W-1:0]                             readback;
	logic                                     busy;
	logic [NUM_LABS-1:0]                      req;
	logic [NUM_LABS-1:0]                      shf_ack;
	logic [NUM_LABS-1:0]                      mask;
	logic [NUM_LABS*W-1:0]                    shf_readback;

	lab4_reg_bank #(.NUM_REGCLR(NUM_REGCLR)) u_reg_bank (
		.clk_i(clk_i), .rst_i(rst_i),
		.bus_i(bus_i), .ack_o(ack_o), .rd_data_o(rd_data_o),
		.start_o(start), .cmd_o(cmd), .prescale_o(prescale), .regclr_o(regclr_o),
		.done_i(done), .readback_i(readback), .busy_i(busy)
	);

	lab4_serial_dispatch #(.NUM_LABS(NUM_LABS)) u_dispatch (
		.clk_i(clk_i), .rst_i(rst_i),
		.start_i(start), .cmd_i(cmd), .chan_disable_i(chan_disable_i),
		.req_o(req), .ack_i(shf_ack), .mask_o(mask), .busy_o(busy)
	);

	// one serial engine per chip, all fed the same word
	for (genvar i = 0; i < NUM_LABS; i++) begin : g_lab
		lab4_serial_shifter u_shifter (
			.clk_i(clk_i), .rst_i(rst_i),
			.req_i(req[i]), .ack_o(shf_ack[i]),
			.word_i(cmd.word), .prescale_i(prescale), .shout_i(shout_i[i]),
			.sin_o(sin_o[i]), .sclk_o(sclk_o[i]), .pclk_o(pclk_o[i]),
			.readback_o(shf_readback[i*W +: W])
		);
	end

	lab4_shout_collect #(.NUM_LABS(NUM_LABS)) u_collect (
		.clk_i(clk_i), .rst_i(rst_i),
		.start_i(start), .mask_i(mask), .ack_i(shf_ack),
		.readback_i(shf_readback), .done_o(done), .readback_o(readback)
	);

endmodule

/* tb/lab4_serial_properties.sv */
`timescale 1ns/1ps

module lab4_serial_properties #(
	parameter int NUM_LABS   = 8,
	parameter int NUM_REGCLR = 1
) (
	input logic                    clk_i,
	input logic                    rst_i,
	input lab4_ctrl_pkg::bus_req_t bus_i,
	input logic                    bus_ack_i,
	input logic [NUM_LABS-1:0]     sclk_i,
	input logic [NUM_LABS-1:0]     pclk_i,
	input logic [NUM_REGCLR-1:0]   regclr_i
);

	logic ctrl_write;

	// first cycle of a host write to the control register
	assign ctrl_write = bus_i.cyc && bus_i.stb && bus_i.we && !bus_ack_i
		&& (bus_i.adr == lab4_ctrl_pkg::REG_CONTROL);

	// the word is latched only once the shift clock is back low
	a_pclk_sclk: assert property (@(posedge clk_i) disable iff (rst_i)
		(pclk_i & sclk_i) == '0)
		else $error("pclk high together with sclk on one chip");

	a_ack_after_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(bus_ack_i) |-> $past(bus_i.cyc && bus_i.stb))
		else $error("bus ack rose without cyc and stb");

	a_regclr_follows: assert property (@(posedge clk_i) disable iff (rst_i)
		ctrl_write |=> (regclr_i == $past(bus_i.dat[lab4_ctrl_pkg::REGCLR_LSB +: NUM_REGCLR])))
		else $error("regclr pins differ from the written control field");

	a_regclr_holds: assert property (@(posedge clk_i) disable iff (rst_i)
		!ctrl_write |=> $stable(regclr_i))
		else $error("regclr pins moved without a control write");

endmodule

/* tb/tb_lab4_serial_ctrl.sv */
`timescale 1ns/1ps

module tb_lab4_serial_ctrl;

	localparam int NUM_LABS    = 8;
	localparam int NUM_REGCLR  = 1;
	localparam int W           = lab4_ctrl_pkg::LAB_WORD_WIDTH;
	localparam int DISABLED_LAB = 5;

	// one full shift per serial write at the slowest prescale, plus bus traffic
	localparam int SERIAL_WRITES = 10;
	localparam int MAX_PRESCALE  = 3;
	localparam int TIMEOUT_NS    = SERIAL_WRITES * 50 * (MAX_PRESCALE + 1) * 10 + 20000;

	logic                    clk_i;
	logic                    rst_i;
	lab4_ctrl_pkg::bus_req_t bus;
	logic                    ack;
	logic [31:0]             rd_data;
	logic [NUM_LABS-1:0]     chan_disable;
	logic [NUM_LABS-1:0]     shout;
	logic [NUM_LABS-1:0]     sin;
	logic [NUM_LABS-1:0]     sclk;
	logic [NUM_LABS-1:0]     pclk;
	logic [NUM_REGCLR-1:0]   regclr;
	logic [NUM_LABS*W-1:0]   chip_latch;

	// expected chip contents and the readback word the status should show
	logic [W-1:0] exp_shift [NUM_LABS];
	logic [W-1:0] exp_latch [NUM_LABS];
	logic [W-1:0] exp_readback;

	lab4_serial_ctrl_top #(.NUM_LABS(NUM_LABS), .NUM_REGCLR(NUM_REGCLR)) dut_i (
		.clk_i(clk_i), .rst_i(rst_i), .bus_i(bus), .ack_o(ack), .rd_data_o(rd_data),
		.chan_disable_i(chan_disable), .shout_i(shout),
		.sin_o(sin), .sclk_o(sclk), .pclk_o(pclk), .regclr_o(regclr)
	);

	bind lab4_serial_ctrl_top lab4_serial_properties #(
		.NUM_LABS(NUM_LABS), .NUM_REGCLR(NUM_REGCLR)
	) u_props (
		.clk_i(clk_i), .rst_i(rst_i), .bus_i(bus_i), .bus_ack_i(ack_o),
		.sclk_i(sclk_o), .pclk_i(pclk_o), .regclr_i(regclr_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// LAB4 chip models

	for (genvar g = 0; g < NUM_LABS; g++) begin : g_chip
		logic [W-1:0] shift_q = '0;
		logic [W-1:0] latch_q = 24'hC00000 + W'(g);

		always @(posedge sclk[g]) begin
			shift_q <= {shift_q[W-2:0], sin[g]};
		end

		always @(posedge pclk[g]) begin
			latch_q <= shift_q;
		end

		assign shout[g]             = shift_q[W-1];
		assign chip_latch[g*W +: W] = latch_q;
	end

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout, the DUT never finished its serial writes");
		abort_run("watchdog expired");
	end

	////////////////////////////////////////////////////////////////////////////
	// bus and check helpers

	task automatic abort_run(input string why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			abort_run("register value mismatch");
		end
	endtask

	task automatic check_lab_word(input string name, input logic [W-1:0] exp,
			input logic [W-1:0] act);
		if (act !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			abort_run("latched chip word mismatch");
		end
	endtask

	task automatic check_status(input string name, input lab4_ctrl_pkg::serial_status_t exp,
			input lab4_ctrl_pkg::serial_status_t act);
		if (act !== exp) begin
			$display("ERR %s: expected busy %0b word %h, actual busy %0b word %h",
				name, exp.busy, exp.readback, act.busy, act.readback);
			abort_run("status mismatch");
		end
	endtask

	task automatic bus_write(input logic [6:0] adr, input logic [31:0] dat);
		@(posedge clk_i);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		do begin
			@(posedge clk_i);
		end while (!ack);
		bus <= '0;
	endtask

	task automatic bus_read(input logic [6:0] adr, output logic [31:0] dat);
		@(posedge clk_i);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
		do begin
			@(posedge clk_i);
		end while (!ack);
		dat = rd_data;
		bus <= '0;
	endtask

	task automatic serial_write(input logic [4:0] sel, input logic [W-1:0] word);
		bus_write(lab4_ctrl_pkg::REG_USER_WRITE, {1'b1, 2'b00, sel, word});
	endtask

	// poll the request bit until the engine has finished
	task automatic wait_idle();
		logic [31:0] d;
		do begin
			bus_read(lab4_ctrl_pkg::REG_USER_WRITE, d);
		end while (d[31]);
	endtask

	// expected effect of one serial write on the chips and the readback
	task automatic model_write(input logic [4:0] sel, input logic [W-1:0] word);
		logic found;
		found = 1'b0;
		for (int i = 0; i < NUM_LABS; i++) begin
			if ((sel == 5'h1F || int'(sel) == i) && !chan_disable[i]) begin
				if (!found) begin
					exp_readback = exp_shift[i];
				end
				found        = 1'b1;
				exp_shift[i] = word;
				exp_latch[i] = word;
			end
		end
	endtask

	task automatic verify_after_write(input string name);
		logic [31:0]                   d;
		lab4_ctrl_pkg::serial_status_t st;
		lab4_ctrl_pkg::serial_status_t exp_st;
		for (int i = 0; i < NUM_LABS; i++) begin
			check_lab_word(name, exp_latch[i], chip_latch[i*W +: W]);
		end
		bus_read(lab4_ctrl_pkg::REG_STATUS, d);
		st.busy         = d[31];
		st.readback     = d[W-1:0];
		exp_st.busy     = 1'b0;
		exp_st.readback = exp_readback;
		check_status(name, exp_st, st);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic access_registers();
		logic [31:0] d;
		bus_read(lab4_ctrl_pkg::REG_PRESCALE, d);
		check_word("prescale reset", 32'h1, d);
		bus_write(lab4_ctrl_pkg::REG_PRESCALE, 32'h5);
		bus_read(lab4_ctrl_pkg::REG_PRESCALE, d);
		check_word("prescale write", 32'h5, d);
		bus_write(lab4_ctrl_pkg::REG_CONTROL, 32'h1 << lab4_ctrl_pkg::REGCLR_LSB);
		bus_read(lab4_ctrl_pkg::REG_CONTROL, d);
		check_word("control write", 32'h1 << lab4_ctrl_pkg::REGCLR_LSB, d);
		check_word("regclr pin set", 32'h1, 32'(regclr));
		bus_write(lab4_ctrl_pkg::REG_CONTROL, 32'h0);
		check_word("regclr pin clear", 32'h0, 32'(regclr));
		bus_write(lab4_ctrl_pkg::REG_PRESCALE, 32'h1);
	endtask

	task automatic write_single_chip();
		logic [W-1:0] payload;
		payload = W'($urandom());
		model_write(5'd2, payload);
		serial_write(5'd2, payload);
		wait_idle();
		verify_after_write("single chip");
	endtask

	task automatic read_back_previous();
		logic [W-1:0] payload;
		payload = W'($urandom());
		model_write(5'd4, payload);
		serial_write(5'd4, payload);
		wait_idle();
		verify_after_write("readback first");
		payload = W'($urandom());
		model_write(5'd4, payload);
		serial_write(5'd4, payload);
		wait_idle();
		verify_after_write("readback second");
	endtask

	task automatic broadcast_with_disable();
		logic [W-1:0] payload;
		@(posedge clk_i);
		chan_disable <= NUM_LABS'(1) << DISABLED_LAB;
		@(posedge clk_i);
		payload = W'($urandom());
		model_write(5'h1F, payload);
		serial_write(5'h1F, payload);
		wait_idle();
		verify_after_write("broadcast");
	endtask

	task automatic block_busy_and_empty();
		logic [W-1:0]                  first;
		logic [W-1:0]                  second;
		logic [31:0]                   d;
		lab4_ctrl_pkg::serial_status_t busy_st;
		lab4_ctrl_pkg::serial_status_t exp_busy_st;
		first  = W'($urandom());
		second = W'($urandom());
		// readback word keeps its old value until the collector is done
		exp_busy_st.busy     = 1'b1;
		exp_busy_st.readback = exp_readback;
		model_write(5'd1, first);
		serial_write(5'd1, first);
		// engine is still shifting, so this one must bounce
		serial_write(5'd3, second);
		bus_read(lab4_ctrl_pkg::REG_USER_WRITE, d);
		check_word("back-pressure command", {1'b1, 2'b00, 5'd1, first}, d);
		bus_read(lab4_ctrl_pkg::REG_STATUS, d);
		busy_st.busy     = d[31];
		busy_st.readback = d[W-1:0];
		check_status("busy while shifting", exp_busy_st, busy_st);
		wait_idle();
		verify_after_write("back-pressure");
		serial_write(5'(DISABLED_LAB), second);
		wait_idle();
		verify_after_write("disabled target");
		serial_write(5'd20, second);
		wait_idle();
		verify_after_write("out of range target");
	endtask

	task automatic measure_prescale();
		logic [W-1:0] payload;
		int           pulses;
		int           width;
		bus_write(lab4_ctrl_pkg::REG_PRESCALE, 32'h3);
		payload = W'($urandom());
		pulses  = 0;
		width   = 0;
		model_write(5'd0, payload);
		serial_write(5'd0, payload);
		while (pulses < W) begin
			@(posedge clk_i);
			if (sclk[0]) begin
				width++;
			end else if (width != 0) begin
				check_word("prescale sclk width", 32'd4, 32'(width));
				pulses++;
				width = 0;
			end
		end
		wait_idle();
		verify_after_write("prescale");
	endtask

	initial begin
		void'($urandom(50240));
		rst_i        = 1'b1;
		bus          = '0;
		chan_disable = '0;
		exp_readback = '0;
		for (int i = 0; i < NUM_LABS; i++) begin
			exp_shift[i] = '0;
			exp_latch[i] = 24'hC00000 + W'(i);
		end
		repeat (5) @(posedge clk_i);
		rst_i <= 1'b0;
		access_registers();
		write_single_chip();
		read_back_previous();
		broadcast_with_disable();
		block_busy_and_empty();
		measure_prescale();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* all.f */
design/lab4_ctrl_pkg.sv
design/lab4_reg_bank.sv
design/lab4_serial_dispatch.sv
design/lab4_serial_shifter.sv
design/lab4_shout_collect.sv
design/lab4_serial_ctrl_top.sv
tb/lab4_serial_properties.sv
tb/tb_lab4_serial_ctrl.sv

/* Makefile */
TOP = tb_lab4_serial_ctrl
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ) sim.log
